//--- timer_pkg.sv
// Shared types and constants for the single-channel APB timer
// Register offsets are word addresses, PADDR[4:2]
// The count word is fixed at 32 bits; narrower counters zero-extend into it
// Prescale code 3 is not defined by the register map and behaves as divide by 256
`default_nettype none

package timer_pkg;

  // ----------------------------------------
  // Address map
  // ----------------------------------------

  // Word address taken from PADDR[4:2]
  typedef logic [2:0] addr_t;

  localparam addr_t ADDR_LOAD    = 3'd0;
  localparam addr_t ADDR_VALUE   = 3'd1;
  localparam addr_t ADDR_CONTROL = 3'd2;
  localparam addr_t ADDR_INTCLR  = 3'd3;
  localparam addr_t ADDR_RIS     = 3'd4;
  localparam addr_t ADDR_MIS     = 3'd5;
  localparam addr_t ADDR_BGLOAD  = 3'd6;

  // ----------------------------------------
  // Control register
  // ----------------------------------------

  // Field order matches register bit order, MSB first
  typedef struct packed {
    logic       en;        // Bit 7, counter enable
    logic       periodic;  // Bit 6, reload from period on wrap
    logic       int_en;    // Bit 5, interrupt output mask
    logic       rsvd;      // Bit 4, always reads zero
    logic [1:0] prescale;  // Bits 3:2, divide select
    logic       size32;    // Bit 1, 32-bit count when set
    logic       one_shot;  // Bit 0, stop at zero
  } ctrl_t;

  // Interrupt enable is the only bit set out of reset
  localparam ctrl_t CTRL_RESET = 8'h20;

  // Prescale field codes
  localparam logic [1:0] PRESCALE_DIV1   = 2'd0;
  localparam logic [1:0] PRESCALE_DIV16  = 2'd1;
  localparam logic [1:0] PRESCALE_DIV256 = 2'd2;

  // ----------------------------------------
  // APB write word
  // ----------------------------------------

  // Control view of the write word
  typedef struct packed {
    logic [23:0] rsvd_hi;
    ctrl_t       ctrl;
  } wdata_ctrl_t;

  // Same 32 bits seen as a count value or as control fields
  typedef union packed {
    logic [31:0] value;
    wdata_ctrl_t fields;
  } wdata_u;

  // Count word as seen on the bus
  typedef logic [31:0] count_t;

  // Register block to counter
  typedef struct packed {
    logic   load_req;     // Load pending, taken on next enabled cycle
    count_t load_val;     // Value for that load
    count_t load_period;  // Reload value on periodic wrap
    ctrl_t  ctrl;
  } cnt_req_t;

endpackage

`default_nettype wire

//--- timer_prescaler.sv
// Eight-bit prescale counter for the timer
// Counts down only on cycles with timclken high and the timer enabled
// Restarts from zero when a pending load is taken, so the first period is full
`default_nettype none

module timer_prescaler (
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       timclken,
  input  logic       en,
  input  logic       restart,
  input  logic [1:0] prescale,
  output logic       pre_tick
);

  logic [7:0] pre_cnt;

  // Down-counter, free wrap past zero
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      pre_cnt <= '0;
    else if (timclken)
    begin
      if (restart)
        pre_cnt <= '0;
      else if (en)
        pre_cnt <= pre_cnt - 8'd1;
    end
  end

  // Tick select
  // Low nibble at 1 gives one in 16, whole byte at 1 one in 256
  always_comb
  begin
    case (prescale)
      timer_pkg::PRESCALE_DIV1:
        pre_tick = 1'b1;
      timer_pkg::PRESCALE_DIV16:
        pre_tick = (pre_cnt[3:0] == 4'd1);
      default:
        pre_tick = (pre_cnt == 8'd1);
    endcase
  end

endmodule

`default_nettype wire

//--- timer_down_counter.sv
// Down-counter of the timer, split into two halfwords at COUNT_W/2
// COUNT_W must be even and 16 to 32; the count port zero-extends the value
// Carries are registered, so zero rises on the edge that reaches 0
// In 16-bit mode the upper half holds except on a load or periodic reload
// All state changes only on cycles with timclken high
`default_nettype none

module timer_down_counter #(
  parameter int COUNT_W = 32
) (
  input  logic                PCLK,
  input  logic                PRESETn,
  input  logic                timclken,
  input  logic                pre_tick,
  input  timer_pkg::cnt_req_t cnt_req,
  output timer_pkg::count_t   count,
  output logic                zero,
  output logic                consume
);

  localparam int HW = COUNT_W / 2;

  logic [COUNT_W-1:0] count_q;
  logic [COUNT_W-1:0] count_nxt;
  logic [COUNT_W-1:0] reload_val;
  logic [1:0]         carry_q;
  logic [1:0]         carry_nxt;
  logic               carry_msb;
  logic               stop_q;
  logic               stop_nxt;
  logic               wrap_reload;
  logic               reload;
  logic               step;
  logic [HW-1:0]      dec_low;
  logic [HW-1:0]      dec_high;
  logic [HW-1:0]      high_src;

  // Every enabled cycle takes pending requests
  assign consume = timclken;

  // ----------------------------------------
  // Carry and reload select
  // ----------------------------------------

  // Zero flag of the active width
  assign carry_msb = cnt_req.ctrl.size32 ? carry_q[1] : carry_q[0];
  assign zero      = carry_msb;

  // Periodic wrap takes the period, a load takes the written value
  assign wrap_reload = carry_msb & cnt_req.ctrl.periodic;
  assign reload      = cnt_req.load_req | wrap_reload;
  assign reload_val  = cnt_req.load_req ? cnt_req.load_val[COUNT_W-1:0]
                                        : cnt_req.load_period[COUNT_W-1:0];

  // One-shot stop, released by a load or by leaving one-shot mode
  assign stop_nxt = (cnt_req.load_req || !cnt_req.ctrl.one_shot) ? 1'b0 :
                    carry_msb ? 1'b1 : stop_q;

  // Count moves on a prescaled tick or on a load
  assign step = (cnt_req.ctrl.en & pre_tick & ~stop_nxt) | cnt_req.load_req;

  // ----------------------------------------
  // Halfword decrementers
  // ----------------------------------------

  assign dec_low = count_q[HW-1:0] - HW'(1);

  // Upper half borrows only in 32-bit mode and when the lower half was 0
  always_comb
  begin
    if (cnt_req.ctrl.size32 && carry_q[0])
      dec_high = count_q[COUNT_W-1:HW] - HW'(1);
    else
      dec_high = count_q[COUNT_W-1:HW];
  end

  // Predict the carries for the value about to be stored
  always_comb
  begin
    high_src = reload ? reload_val[COUNT_W-1:HW] : count_q[COUNT_W-1:HW];
    if (reload)
      carry_nxt[0] = (reload_val[HW-1:0] == '0);
    else
      carry_nxt[0] = (count_q[HW-1:0] == HW'(1));
    // 16-bit mode mirrors the low carry so a size change stays clean
    if (!cnt_req.ctrl.size32)
      carry_nxt[1] = carry_nxt[0];
    else
      carry_nxt[1] = carry_nxt[0] & (high_src == '0);
  end

  // Load first, then periodic reload, then plain decrement
  always_comb
  begin
    if (cnt_req.load_req)
      count_nxt = cnt_req.load_val[COUNT_W-1:0];
    else if (wrap_reload)
      count_nxt = cnt_req.load_period[COUNT_W-1:0];
    else
      count_nxt = {dec_high, dec_low};
  end

  // ----------------------------------------
  // State
  // ----------------------------------------

  // All ones out of reset keeps zero low
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      count_q <= '1;
      carry_q <= '0;
      stop_q  <= 1'b0;
    end
    else if (timclken)
    begin
      stop_q <= stop_nxt;
      if (step)
      begin
        count_q <= count_nxt;
        carry_q <= carry_nxt;
      end
    end
  end

  assign count = timer_pkg::count_t'(count_q);

endmodule

`default_nettype wire

//--- timer_irq.sv
// Interrupt logic of the timer
// The raw latch sets on the enabled edge after zero rises
// A clear request holds until zero falls, so one count event interrupts once
// raw_int already reflects a pending clear, before the next enabled cycle
`default_nettype none

module timer_irq (
  input  logic PCLK,
  input  logic PRESETn,
  input  logic timclken,
  input  logic zero,
  input  logic clr_req,
  input  logic int_en,
  output logic raw_int,
  output logic masked_int
);

  logic raw_q;
  logic clr_hold_q;
  logic clr_active;

  // Clear stays active while the counter sits at zero
  assign clr_active = clr_req ? 1'b1 : (zero ? clr_hold_q : 1'b0);

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      raw_q      <= 1'b0;
      clr_hold_q <= 1'b0;
    end
    else if (timclken)
    begin
      clr_hold_q <= clr_active;
      // Set on zero, hold until cleared
      raw_q      <= (zero | raw_q) & ~clr_active;
    end
  end

  // Status as read back and as driven out
  assign raw_int    = raw_q & ~clr_active;
  assign masked_int = raw_int & int_en;

endmodule

`default_nettype wire

//--- timer_apb_regs.sv
// APB register block of one timer channel
// Writes take effect in the setup phase: psel and pwrite high, penable low
// Read data is combinational and zero unless psel is high and pwrite low
// No wait states and no error response
// Load and interrupt clear stay pending until the next cycle with consume high
`default_nettype none

module timer_apb_regs (
  input  logic                PCLK,
  input  logic                PRESETn,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  timer_pkg::addr_t    paddr,
  input  timer_pkg::wdata_u   pwdata,
  input  timer_pkg::count_t   count,
  input  logic                raw_int,
  input  logic                masked_int,
  input  logic                consume,
  output timer_pkg::cnt_req_t cnt_req,
  output logic                clr_req,
  output timer_pkg::count_t   prdata
);

  logic               wr_en;
  logic               ctrl_wr;
  logic               load_wr;
  logic               bgload_wr;
  logic               clr_wr;
  timer_pkg::ctrl_t   ctrl_q;
  timer_pkg::ctrl_t   ctrl_wdata;
  timer_pkg::count_t  load_val_q;
  timer_pkg::count_t  load_period_q;
  logic               load_req_q;
  logic               clr_req_q;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------

  // Setup phase only, so each transfer writes once
  assign wr_en     = psel & pwrite & ~penable;
  assign ctrl_wr   = wr_en & (paddr == timer_pkg::ADDR_CONTROL);
  assign load_wr   = wr_en & (paddr == timer_pkg::ADDR_LOAD);
  assign bgload_wr = wr_en & (paddr == timer_pkg::ADDR_BGLOAD);
  assign clr_wr    = wr_en & (paddr == timer_pkg::ADDR_INTCLR);

  // Control view of the write word, reserved bit forced low
  always_comb
  begin
    ctrl_wdata      = pwdata.fields.ctrl;
    ctrl_wdata.rsvd = 1'b0;
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ctrl_q        <= timer_pkg::CTRL_RESET;
      load_val_q    <= '0;
      load_period_q <= '0;
    end
    else
    begin
      if (ctrl_wr)
        ctrl_q <= ctrl_wdata;
      // Load goes to the counter on the next enabled cycle
      if (load_wr)
        load_val_q <= pwdata.value;
      // Period follows both load and background load
      if (load_wr || bgload_wr)
        load_period_q <= pwdata.value;
    end
  end

  // Pending flags, a new write wins over a consume on the same edge
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_req_q <= 1'b0;
      clr_req_q  <= 1'b0;
    end
    else
    begin
      if (load_wr)
        load_req_q <= 1'b1;
      else if (consume)
        load_req_q <= 1'b0;
      if (clr_wr)
        clr_req_q <= 1'b1;
      else if (consume)
        clr_req_q <= 1'b0;
    end
  end

  // To the counter and interrupt logic
  assign cnt_req.load_req    = load_req_q;
  assign cnt_req.load_val    = load_val_q;
  assign cnt_req.load_period = load_period_q;
  assign cnt_req.ctrl        = ctrl_q;
  assign clr_req             = clr_req_q;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------

  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (paddr)
        // Both load addresses return the next wrap value
        timer_pkg::ADDR_LOAD,
        timer_pkg::ADDR_BGLOAD:
          prdata = load_period_q;
        // A pending load reads back before the counter takes it
        timer_pkg::ADDR_VALUE:
          prdata = load_req_q ? load_val_q : count;
        timer_pkg::ADDR_CONTROL:
          prdata[7:0] = ctrl_q;
        timer_pkg::ADDR_RIS:
          prdata[0] = raw_int;
        timer_pkg::ADDR_MIS:
          prdata[0] = masked_int;
        default:
          prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- apb_timer.sv
// One channel of an APB dual timer, everything on PCLK
// timclken is a count enable, not a separate clock
// COUNT_W sets the counter width, even values from 16 to 32
// Read data is combinational; there is no PREADY or PSLVERR
`default_nettype none

module apb_timer #(
  parameter int COUNT_W = 32
) (
  input  logic              PCLK,
  input  logic              PRESETn,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  timer_pkg::addr_t  paddr,
  input  timer_pkg::wdata_u pwdata,
  input  logic              timclken,
  output timer_pkg::count_t prdata,
  output logic              timer_int
);

  timer_pkg::cnt_req_t cnt_req;
  timer_pkg::count_t   count;
  logic                clr_req;
  logic                pre_tick;
  logic                zero;
  logic                consume;
  logic                raw_int;
  logic                masked_int;

  // ----------------------------------------
  // Register block
  // ----------------------------------------

  timer_apb_regs u_regs (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .count      (count),
    .raw_int    (raw_int),
    .masked_int (masked_int),
    .consume    (consume),
    .cnt_req    (cnt_req),
    .clr_req    (clr_req),
    .prdata     (prdata)
  );

  // ----------------------------------------
  // Count path
  // ----------------------------------------

  // Prescaler restarts whenever a load is pending
  timer_prescaler u_prescaler (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .timclken (timclken),
    .en       (cnt_req.ctrl.en),
    .restart  (cnt_req.load_req),
    .prescale (cnt_req.ctrl.prescale),
    .pre_tick (pre_tick)
  );

  timer_down_counter #(
    .COUNT_W (COUNT_W)
  ) u_counter (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .timclken (timclken),
    .pre_tick (pre_tick),
    .cnt_req  (cnt_req),
    .count    (count),
    .zero     (zero),
    .consume  (consume)
  );

  // Interrupt
  timer_irq u_irq (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .timclken   (timclken),
    .zero       (zero),
    .clr_req    (clr_req),
    .int_en     (cnt_req.ctrl.int_en),
    .raw_int    (raw_int),
    .masked_int (masked_int)
  );

  assign timer_int = masked_int;

endmodule

`default_nettype wire

//--- apb_timer_properties.sv
// Concurrent checks bound into the APB timer top level
// Reads from pending-load and interrupt logic are checked at PCLK edges
`default_nettype none

module apb_timer_properties (
  input wire logic              PCLK,
  input wire logic              PRESETn,
  input wire logic              psel,
  input wire logic              penable,
  input wire logic              pwrite,
  input wire timer_pkg::addr_t  paddr,
  input wire timer_pkg::count_t prdata,
  input wire logic              raw_int,
  input wire logic              masked_int,
  input wire logic              load_req,
  input wire logic              consume
);

  timeunit 1ns;
  timeprecision 100ps;

  logic load_wr;

  // A new load write keeps the flag set
  assign load_wr = psel & pwrite & ~penable & (paddr == timer_pkg::ADDR_LOAD);

  // ----------------------------------------
  // Interrupt and handshake rules
  // ----------------------------------------

  a_mask_needs_raw: assert property (@(posedge PCLK) disable iff (!PRESETn)
    masked_int |-> raw_int)
    else $error("masked interrupt high without raw interrupt");

  a_consume_clears_load: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (consume && load_req && !load_wr) |=> !load_req)
    else $error("pending load not cleared by consume");

  a_idle_rdata_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (!psel || pwrite) |-> (prdata == '0))
    else $error("read data not zero outside a read");

endmodule

bind apb_timer apb_timer_properties i_props (
  .PCLK       (PCLK),
  .PRESETn    (PRESETn),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .prdata     (prdata),
  .raw_int    (raw_int),
  .masked_int (masked_int),
  .load_req   (cnt_req.load_req),
  .consume    (consume)
);

`default_nettype wire

//--- tb_apb_timer.sv
// Testbench for the single-channel APB timer
// A cycle model of the timer runs beside the DUT and predicts every read
// Rows of the stimulus table run in order and share state from row to row
// The test run assumes COUNT_W of 32
`default_nettype none

module tb_apb_timer;

  timeunit 1ns;
  timeprecision 100ps;

  // One table row, expected RIS of 2 means no fixed RIS or MIS
  typedef struct packed {
    logic [3:0]  test_id;
    logic [7:0]  ctrl;
    logic        do_clr;
    logic        do_load;
    logic [31:0] load;
    logic        do_bg;
    logic [31:0] bgload;
    logic        rand_en;
    logic [15:0] wait_cyc;
    logic [1:0]  exp_ris;
  } row_t;

  localparam int NUM_ROWS = 14;
  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'd1, 8'hA2, 1'b0, 1'b1, 32'd100, 1'b0, 32'd0, 1'b0, 16'd0, 2'd2},
    '{4'd1, 8'hA2, 1'b0, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0, 16'd20, 2'd0},
    '{4'd2, 8'hE2, 1'b0, 1'b1, 32'd8, 1'b0, 32'd0, 1'b0, 16'd20, 2'd1},
    '{4'd2, 8'hE2, 1'b0, 1'b0, 32'd0, 1'b1, 32'd30, 1'b0, 16'd5, 2'd2},
    '{4'd2, 8'hE2, 1'b0, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0, 16'd40, 2'd1},
    '{4'd3, 8'hA3, 1'b1, 1'b1, 32'd4, 1'b0, 32'd0, 1'b0, 16'd20, 2'd1},
    '{4'd3, 8'hA2, 1'b1, 1'b1, 32'd3, 1'b0, 32'd0, 1'b0, 16'd10, 2'd1},
    '{4'd4, 8'hA0, 1'b1, 1'b1, 32'h0005_0003, 1'b0, 32'd0, 1'b0, 16'd10, 2'd1},
    '{4'd4, 8'hA6, 1'b1, 1'b1, 32'd1000, 1'b0, 32'd0, 1'b0, 16'd100, 2'd0},
    '{4'd4, 8'hAA, 1'b1, 1'b1, 32'd1000, 1'b0, 32'd0, 1'b0, 16'd600, 2'd0},
    '{4'd5, 8'hA3, 1'b1, 1'b1, 32'd2, 1'b0, 32'd0, 1'b0, 16'd20, 2'd1},
    '{4'd5, 8'h83, 1'b1, 1'b0, 32'd0, 1'b0, 32'd0, 1'b0, 16'd5, 2'd0},
    '{4'd6, 8'hE2, 1'b1, 1'b1, 32'd50, 1'b0, 32'd0, 1'b1, 16'd300, 2'd2},
    '{4'd6, 8'hA2, 1'b1, 1'b1, 32'd20, 1'b0, 32'd0, 1'b1, 16'd200, 2'd2}
  };

  logic              PCLK;
  logic              PRESETn;
  logic              psel;
  logic              penable;
  logic              pwrite;
  timer_pkg::addr_t  paddr;
  timer_pkg::wdata_u pwdata;
  logic              timclken;
  timer_pkg::count_t prdata;
  logic              timer_int;

  logic [31:0] rng = 32'hb426;
  logic        rand_mode = 1'b0;
  logic [31:0] rd_data;
  int          errors = 0;
  int          row_errors = 0;
  int          rows_failed = 0;

  // Model state
  timer_pkg::ctrl_t m_ctrl;
  logic [31:0]      m_count;
  logic [31:0]      m_load_val;
  logic [31:0]      m_period;
  logic [7:0]       m_pre;
  logic             m_zero;
  logic             m_stop;
  logic             m_raw;
  logic             m_hold;
  logic             m_load_req;
  logic             m_clr_req;

  apb_timer i_dut (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .timclken  (timclken),
    .prdata    (prdata),
    .timer_int (timer_int)
  );

  initial
  begin
    PCLK = 1'b0;
    forever
      #4 PCLK = ~PCLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Count enable, random only in the rows that ask for it
  always @(posedge PCLK)
  begin
    if (rand_mode)
    begin
      rng = xorshift(rng);
      timclken <= rng[0];
    end
    else
      timclken <= 1'b1;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Sees inputs as they were before the edge, like the DUT
  always @(posedge PCLK)
  begin : model
    logic        wr;
    logic        tick;
    logic        stop_n;
    logic        step;
    logic        clr_act;
    logic [31:0] nv;
    if (!PRESETn)
    begin
      m_ctrl     = timer_pkg::CTRL_RESET;
      m_count    = 32'hFFFF_FFFF;
      m_load_val = 32'd0;
      m_period   = 32'd0;
      m_pre      = 8'd0;
      m_zero     = 1'b0;
      m_stop     = 1'b0;
      m_raw      = 1'b0;
      m_hold     = 1'b0;
      m_load_req = 1'b0;
      m_clr_req  = 1'b0;
    end
    else
    begin
      wr = psel & pwrite & ~penable;
      if (timclken)
      begin
        // Prescaler tick from the current prescale count
        if (m_ctrl.prescale == 2'd0)
          tick = 1'b1;
        else if (m_ctrl.prescale == 2'd1)
          tick = (m_pre[3:0] == 4'd1);
        else
          tick = (m_pre == 8'd1);
        stop_n = (m_load_req || !m_ctrl.one_shot) ? 1'b0 : (m_zero ? 1'b1 : m_stop);
        step   = (m_ctrl.en & tick & ~stop_n) | m_load_req;
        // Interrupt sees zero from before this edge
        clr_act = m_clr_req | (m_zero & m_hold);
        m_hold  = clr_act;
        m_raw   = (m_zero | m_raw) & ~clr_act;
        if (step)
        begin
          if (m_load_req)
            nv = m_load_val;
          else if (m_zero && m_ctrl.periodic)
            nv = m_period;
          else if (m_ctrl.size32)
            nv = m_count - 32'd1;
          else
            nv = {m_count[31:16], m_count[15:0] - 16'd1};
          m_count = nv;
          m_zero  = m_ctrl.size32 ? (nv == 32'd0) : (nv[15:0] == 16'd0);
        end
        m_stop = stop_n;
        if (m_load_req)
          m_pre = 8'd0;
        else if (m_ctrl.en)
          m_pre = m_pre - 8'd1;
        m_load_req = 1'b0;
        m_clr_req  = 1'b0;
      end
      // Register writes, a write wins over the consume above
      if (wr && paddr == timer_pkg::ADDR_CONTROL)
      begin
        m_ctrl      = pwdata.fields.ctrl;
        m_ctrl.rsvd = 1'b0;
      end
      if (wr && paddr == timer_pkg::ADDR_LOAD)
      begin
        m_load_val = pwdata.value;
        m_period   = pwdata.value;
        m_load_req = 1'b1;
      end
      if (wr && paddr == timer_pkg::ADDR_BGLOAD)
        m_period = pwdata.value;
      if (wr && paddr == timer_pkg::ADDR_INTCLR)
        m_clr_req = 1'b1;
    end
  end

  function automatic logic model_ris();
    return m_raw & ~(m_clr_req | (m_zero & m_hold));
  endfunction

  function automatic logic [31:0] model_read(input timer_pkg::addr_t a);
    case (a)
      timer_pkg::ADDR_LOAD,
      timer_pkg::ADDR_BGLOAD:
        return m_period;
      timer_pkg::ADDR_VALUE:
        return m_load_req ? m_load_val : m_count;
      timer_pkg::ADDR_CONTROL:
        return {24'd0, m_ctrl};
      timer_pkg::ADDR_RIS:
        return {31'd0, model_ris()};
      timer_pkg::ADDR_MIS:
        return {31'd0, model_ris() & m_ctrl.int_en};
      default:
        return 32'd0;
    endcase
  endfunction

  // ----------------------------------------
  // APB access and checks
  // ----------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      row_errors++;
    end
  endtask

  task automatic apb_write(input timer_pkg::addr_t a, input logic [31:0] data);
    @(posedge PCLK);
    psel         <= 1'b1;
    pwrite       <= 1'b1;
    penable      <= 1'b0;
    paddr        <= a;
    pwdata.value <= data;
    @(posedge PCLK);
    penable <= 1'b1;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Read data and timer_int sampled mid-cycle, against the model
  task automatic read_and_check(input timer_pkg::addr_t a, input string name);
    @(posedge PCLK);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    penable <= 1'b0;
    paddr   <= a;
    @(negedge PCLK);
    check_value(name, prdata, model_read(a));
    check_value("timer_int", {31'd0, timer_int}, {31'd0, model_ris() & m_ctrl.int_en});
    rd_data = prdata;
    @(posedge PCLK);
    penable <= 1'b1;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // ----------------------------------------
  // Watchdog and main sequence
  // ----------------------------------------

  initial
  begin : watchdog
    int cycles;
    cycles = 300;
    for (int i = 0; i < NUM_ROWS; i++)
      cycles += int'(ROWS[i].wait_cyc) + 40;
    #(cycles * 8);
    $display("Timeout after %0d cycles, DUT did not finish", cycles);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    PRESETn      = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata.value = 32'd0;
    timclken     = 1'b1;
    repeat (2) @(posedge PCLK);
    PRESETn <= 1'b1;
    // Reset values come straight from the register map
    @(negedge PCLK);
    check_value("timer_int", {31'd0, timer_int}, 32'd0);
    read_and_check(timer_pkg::ADDR_CONTROL, "CONTROL");
    check_value("CONTROL reset", rd_data, 32'h0000_0020);
    read_and_check(timer_pkg::ADDR_VALUE, "VALUE");
    check_value("VALUE reset", rd_data, 32'hFFFF_FFFF);
    $display("Test 0 reset: %s", (errors == 0) ? "ok" : "FAIL");
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      row_errors = 0;
      rand_mode  <= ROWS[i].rand_en;
      apb_write(timer_pkg::ADDR_CONTROL, {24'd0, ROWS[i].ctrl});
      if (ROWS[i].do_clr)
        apb_write(timer_pkg::ADDR_INTCLR, 32'd0);
      if (ROWS[i].do_load)
        apb_write(timer_pkg::ADDR_LOAD, ROWS[i].load);
      if (ROWS[i].do_bg)
        apb_write(timer_pkg::ADDR_BGLOAD, ROWS[i].bgload);
      repeat (int'(ROWS[i].wait_cyc)) @(posedge PCLK);
      read_and_check(timer_pkg::ADDR_VALUE, "VALUE");
      read_and_check(timer_pkg::ADDR_LOAD, "LOAD");
      read_and_check(timer_pkg::ADDR_CONTROL, "CONTROL");
      read_and_check(timer_pkg::ADDR_RIS, "RIS");
      // Hand-derived RIS where the row fixes it
      if (ROWS[i].exp_ris != 2'd2)
        check_value("RIS table", rd_data, {31'd0, ROWS[i].exp_ris[0]});
      read_and_check(timer_pkg::ADDR_MIS, "MIS");
      // MIS is that RIS gated by the row's interrupt enable
      if (ROWS[i].exp_ris != 2'd2)
        check_value("MIS table", rd_data, {31'd0, ROWS[i].exp_ris[0] & ROWS[i].ctrl[5]});
      if (row_errors != 0)
        rows_failed++;
      $display("Test %0d row %0d: %s", ROWS[i].test_id, i, (row_errors == 0) ? "ok" : "FAIL");
    end
    rand_mode <= 1'b0;
    $display("Rows run %0d, rows failed %0d, errors %0d", NUM_ROWS, rows_failed, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
timer_pkg.sv
timer_prescaler.sv
timer_down_counter.sv
timer_irq.sv
timer_apb_regs.sv
apb_timer.sv
apb_timer_properties.sv
tb_apb_timer.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the APB timer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_apb_timer \
  -f vlog.f \
  -o sim_apb_timer

./obj_dir/sim_apb_timer > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi
